// File: verilog/fetchPkg.sv
`default_nettype none

package fetchPkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] instT;

    // 0,1 not taken / 2,3 taken
    typedef logic [1:0] ctrT;

    localparam ctrT CTR_INIT = 2'd1; // weakly not taken

    localparam addrT PC_RESET = 32'hBFC00000;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_REGIMM = 6'd1;
    localparam logic [5:0] OP_J      = 6'd2;
    localparam logic [5:0] OP_JAL    = 6'd3;
    localparam logic [5:0] OP_BEQ    = 6'd4;
    localparam logic [5:0] OP_BNE    = 6'd5;
    localparam logic [5:0] OP_BLEZ   = 6'd6;
    localparam logic [5:0] OP_BGTZ   = 6'd7;

endpackage

`default_nettype wire

// File: verilog/resolveIf.sv
`timescale 1ns/1ns
`default_nettype none

interface resolveIf;
    import fetchPkg::*;

    logic valid;     // one-cycle report
    addrT pc;        // pc of the resolved branch
    logic taken;
    logic predTaken; // prediction carried down the pipe
    addrT target;

    // predictor training only
    modport branchSink (
        input valid, pc, taken
    );

    modport ctrlSink (
        input valid, pc, taken, predTaken, target
    );

endinterface

`default_nettype wire

// File: verilog/branchPredict.sv
`timescale 1ns/1ns
`default_nettype none

module branchPredict #(
    parameter int BHT_BITS = 6
) (
    input  logic              clk,
    input  logic              rstN_i,
    input  fetchPkg::addrT    pc_i,
    input  fetchPkg::instT    inst_i,
    resolveIf.branchSink      res,
    output logic              isBranch_o,
    output logic              predTaken_o,
    output fetchPkg::addrT    branchTarget_o
);
    import fetchPkg::*;

    localparam int DEPTH = 2 ** BHT_BITS;

    ctrT bht [DEPTH];

    logic [5:0] opcode;
    logic [BHT_BITS-1:0] rdIdx;
    logic [BHT_BITS-1:0] wrIdx;
    addrT offset;
    ctrT rdCtr;
    ctrT wrCtr;

    assign opcode = inst_i[31:26];

    always_comb begin
        case (opcode)
            OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: isBranch_o = 1'b1;
            default: isBranch_o = 1'b0;
        endcase
    end

    // sign-extended word offset, relative to pc+4
    assign offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign branchTarget_o = pc_i + 32'd4 + offset;

    assign rdIdx = pc_i[BHT_BITS+1:2];
    assign rdCtr = bht[rdIdx];
    assign predTaken_o = isBranch_o & rdCtr[1];

    assign wrIdx = res.pc[BHT_BITS+1:2];
    assign wrCtr = bht[wrIdx];

    // saturating 2-bit update on every report
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                bht[i] <= CTR_INIT;
            end
        end else if (res.valid) begin
            if (res.taken) begin
                if (wrCtr != 2'b11)
                    bht[wrIdx] <= wrCtr + 2'b01;
            end else begin
                if (wrCtr != 2'b00)
                    bht[wrIdx] <= wrCtr - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/jumpPredict.sv
`timescale 1ns/1ns
`default_nettype none

module jumpPredict (
    input  fetchPkg::addrT pc_i,
    input  fetchPkg::instT inst_i,
    output logic           isJump_o,
    output fetchPkg::addrT jumpTarget_o
);
    import fetchPkg::*;

    logic [5:0] opcode;
    addrT pcPlus4;

    assign opcode = inst_i[31:26];
    assign pcPlus4 = pc_i + 32'd4;

    // J and JAL only, register jumps get resolved later
    assign isJump_o = (opcode == OP_J) || (opcode == OP_JAL);

    // pseudo-direct: region bits from pc+4
    assign jumpTarget_o = {pcPlus4[31:28], inst_i[25:0], 2'b00};

endmodule

`default_nettype wire

// File: verilog/pcCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module pcCtrl #(
    parameter int CREDITS = 4
) (
    input  logic           clk,
    input  logic           rstN_i,
    input  fetchPkg::instT imemData_i,
    input  logic           credit_i,
    resolveIf.ctrlSink     res,
    input  logic           isBranch_i,
    input  logic           predTaken_i,
    input  fetchPkg::addrT branchTarget_i,
    input  logic           isJump_i,
    input  fetchPkg::addrT jumpTarget_i,
    output fetchPkg::addrT pc_o,
    output logic           instValid_o,
    output fetchPkg::instT instWord_o,
    output fetchPkg::addrT instPc_o,
    output logic           predTaken_o
);
    import fetchPkg::*;

    localparam int CW = $clog2(CREDITS + 1);

    addrT pcQ;
    addrT pcPlus4;
    addrT redirectPc;
    addrT seqNext;
    logic [CW-1:0] creditQ;
    logic haveCredit;
    logic mispredict;
    logic issue;

    assign pcPlus4 = pcQ + 32'd4;

    // resolution disagrees with what fetch guessed
    assign mispredict = res.valid && (res.taken != res.predTaken);
    assign redirectPc = res.taken ? res.target : res.pc + 32'd4;

    assign haveCredit = (creditQ != '0);
    assign issue = haveCredit && !mispredict;

    // jump beats predicted branch beats fall-through
    always_comb begin
        if (isJump_i)
            seqNext = jumpTarget_i;
        else if (isBranch_i && predTaken_i)
            seqNext = branchTarget_i;
        else
            seqNext = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcQ <= PC_RESET;
        end else if (mispredict) begin
            pcQ <= redirectPc;
        end else if (issue) begin
            pcQ <= seqNext;
        end
        // hold without credit
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            creditQ <= CW'(CREDITS);
        end else begin
            case ({issue, credit_i})
                2'b10: creditQ <= creditQ - CW'(1); // spend
                2'b01: creditQ <= creditQ + CW'(1); // return
                default: creditQ <= creditQ;
            endcase
        end
    end

    assign pc_o = pcQ;
    assign instValid_o = issue;
    assign instWord_o = imemData_i;
    assign instPc_o = pcQ;
    assign predTaken_o = issue && isBranch_i && predTaken_i;

endmodule

`default_nettype wire

// File: verilog/fetchFront.sv
`timescale 1ns/1ns
`default_nettype none

module fetchFront #(
    parameter int BHT_BITS = 6,
    parameter int CREDITS  = 4
) (
    input  logic           clk,
    input  logic           rstN_i,
    output fetchPkg::addrT imemAddr_o,
    input  fetchPkg::instT imemData_i,
    output logic           instValid_o,
    output fetchPkg::instT instWord_o,
    output fetchPkg::addrT instPc_o,
    output logic           predTaken_o,
    input  logic           credit_i,
    input  logic           resolveValid_i,
    input  fetchPkg::addrT resolvePc_i,
    input  logic           resolveTaken_i,
    input  logic           resolvePredTaken_i,
    input  fetchPkg::addrT resolveTarget_i
);
    import fetchPkg::*;

    addrT pc;
    logic isBranch;
    logic bpTaken;
    addrT branchTarget;
    logic isJump;
    addrT jumpTarget;

    resolveIf resBus ();

    assign resBus.valid     = resolveValid_i;
    assign resBus.pc        = resolvePc_i;
    assign resBus.taken     = resolveTaken_i;
    assign resBus.predTaken = resolvePredTaken_i;
    assign resBus.target    = resolveTarget_i;

    assign imemAddr_o = pc; // memory answers same cycle

    branchPredict #(.BHT_BITS(BHT_BITS)) branchPredict0 (
        .clk(clk), .rstN_i(rstN_i),
        .pc_i(pc), .inst_i(imemData_i),
        .res(resBus.branchSink),
        .isBranch_o(isBranch),
        .predTaken_o(bpTaken),
        .branchTarget_o(branchTarget)
    );

    jumpPredict jumpPredict0 (
        .pc_i(pc), .inst_i(imemData_i),
        .isJump_o(isJump),
        .jumpTarget_o(jumpTarget)
    );

    pcCtrl #(.CREDITS(CREDITS)) pcCtrl0 (
        .clk(clk), .rstN_i(rstN_i),
        .imemData_i(imemData_i),
        .credit_i(credit_i),
        .res(resBus.ctrlSink),
        .isBranch_i(isBranch), .predTaken_i(bpTaken), .branchTarget_i(branchTarget),
        .isJump_i(isJump), .jumpTarget_i(jumpTarget),
        .pc_o(pc),
        .instValid_o(instValid_o),
        .instWord_o(instWord_o),
        .instPc_o(instPc_o),
        .predTaken_o(predTaken_o)
    );

endmodule

`default_nettype wire

// File: verification/fetchFront_properties.sv
`timescale 1ns/1ns
`default_nettype none

module fetchFront_properties #(
    parameter int CREDITS = 4
) (
    input logic                               clk,
    input logic                               rstN_i,
    input logic                               instValid_i,
    input logic                               resolveValid_i,
    input logic                               resolveTaken_i,
    input logic                               resolvePredTaken_i,
    input logic [$clog2(CREDITS + 1)-1:0]     creditCnt_i
);
    localparam int CW = $clog2(CREDITS + 1);
    localparam logic [CW-1:0] MAX_CREDIT = CW'(CREDITS);

    // decode buffer can never be oversubscribed
    creditsBounded: assert property (
        @(posedge clk) disable iff (!rstN_i)
        creditCnt_i <= MAX_CREDIT
    ) else $error("credit count went above the decode buffer depth");

    noIssueWithoutCredit: assert property (
        @(posedge clk) disable iff (!rstN_i)
        instValid_i |-> (creditCnt_i != '0)
    ) else $error("word issued while no credit was held");

    // redirect cycle drops the fetched word
    mispredictBlocksIssue: assert property (
        @(posedge clk) disable iff (!rstN_i)
        (resolveValid_i && (resolveTaken_i != resolvePredTaken_i)) |-> !instValid_i
    ) else $error("word issued in a misprediction cycle");

endmodule

`default_nettype wire

// File: verification/fetchFront_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetchFront_tb;
    import fetchPkg::*;

    localparam int CREDITS = 4;
    localparam int BHT_BITS = 6;
    localparam int RAND_CYCLES = 12;
    localparam addrT BASE = PC_RESET;

    typedef struct packed {
        logic credit;
        logic rv;
        addrT rpc;
        logic rt;
        logic rpt;
        addrT rtgt;
        logic expIssue;
    } stepT;

    logic clk;
    logic rstN;
    addrT imemAddr;
    instT imemData;
    logic instValid;
    instT instWord;
    addrT instPc;
    logic predTaken;
    logic credit;
    logic resValid;
    addrT resPc;
    logic resTaken;
    logic resPredTaken;
    addrT resTarget;

    instT rom [64];
    stepT steps [$];
    bit tableReady;

    // reference model
    addrT mPc;
    int mCredits;
    ctrT mCtr [2 ** BHT_BITS];

    fetchFront #(.BHT_BITS(BHT_BITS), .CREDITS(CREDITS)) dut_i (
        .clk(clk), .rstN_i(rstN),
        .imemAddr_o(imemAddr), .imemData_i(imemData),
        .instValid_o(instValid), .instWord_o(instWord),
        .instPc_o(instPc), .predTaken_o(predTaken),
        .credit_i(credit),
        .resolveValid_i(resValid), .resolvePc_i(resPc),
        .resolveTaken_i(resTaken), .resolvePredTaken_i(resPredTaken),
        .resolveTarget_i(resTarget)
    );

    bind fetchFront fetchFront_properties #(.CREDITS(CREDITS)) props_i (
        .clk(clk), .rstN_i(rstN_i),
        .instValid_i(instValid_o),
        .resolveValid_i(resolveValid_i),
        .resolveTaken_i(resolveTaken_i),
        .resolvePredTaken_i(resolvePredTaken_i),
        .creditCnt_i(pcCtrl0.creditQ)
    );

    always #20 clk = ~clk;

    // opcode 0 filler, never a branch or jump
    function automatic instT fillWord(input addrT a);
        return {6'd0, a[27:2] ^ {20'd0, a[31:28], a[1:0]}};
    endfunction

    function automatic instT memWord(input addrT a);
        if (a[31:8] == BASE[31:8])
            return rom[a[7:2]];
        return fillWord(a);
    endfunction

    always_comb begin
        if (imemAddr[31:8] == BASE[31:8])
            imemData = rom[imemAddr[7:2]];
        else
            imemData = fillWord(imemAddr);
    end

    task automatic stopOnError();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkInst(input string name, input instT got, input instT exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stopOnError();
        end
    endtask

    task automatic loadImage();
        addrT loopTop;
        for (int i = 0; i < 64; i++) begin
            rom[i] = fillWord(BASE + addrT'(i * 4));
        end
        loopTop = BASE + 32'h40;
        rom[3] = {OP_J, loopTop[27:2]};          // 0x0c
        rom[18] = {OP_BEQ, 5'd1, 5'd2, 16'd13};  // 0x48, target 0x80
        rom[32] = {OP_JAL, loopTop[27:2]};       // 0x80 back to 0x40
    endtask

    task automatic plainStep(input logic cr, input logic expIssue);
        stepT s;
        s = '0;
        s.credit = cr;
        s.expIssue = expIssue;
        steps.push_back(s);
    endtask

    task automatic resolveStep(input logic cr, input addrT pc, input logic taken,
                               input logic predT, input addrT tgt, input logic expIssue);
        stepT s;
        s = '0;
        s.credit = cr;
        s.rv = 1'b1;
        s.rpc = pc;
        s.rt = taken;
        s.rpt = predT;
        s.rtgt = tgt;
        s.expIssue = expIssue;
        steps.push_back(s);
    endtask

    task automatic buildTable();
        for (int i = 0; i < 7; i++) begin
            plainStep(1'b1, 1'b1); // 0x00..0x48, J at 0x0c
        end
        resolveStep(1'b0, BASE + 32'h48, 1'b1, 1'b0, BASE + 32'h80, 1'b0);
        for (int i = 0; i < 4; i++) begin
            plainStep(1'b1, 1'b1); // JAL, 0x40, 0x44, branch now taken
        end
        resolveStep(1'b1, BASE + 32'h48, 1'b1, 1'b1, BASE + 32'h80, 1'b1);
        for (int i = 0; i < 3; i++) begin
            plainStep(1'b1, 1'b1);
        end
        resolveStep(1'b0, BASE + 32'h48, 1'b0, 1'b1, BASE + 32'h80, 1'b0);
        plainStep(1'b1, 1'b1);
        // register jump resolved late
        resolveStep(1'b0, BASE + 32'h44, 1'b1, 1'b0, BASE + 32'ha0, 1'b0);
        plainStep(1'b1, 1'b1);
        resolveStep(1'b1, BASE + 32'hc0, 1'b0, 1'b0, BASE, 1'b1);
        for (int i = 0; i < CREDITS; i++) begin
            plainStep(1'b0, 1'b1);
        end
        plainStep(1'b0, 1'b0);
        plainStep(1'b0, 1'b0);
        plainStep(1'b1, 1'b0);
        plainStep(1'b0, 1'b1);
        plainStep(1'b0, 1'b0);
        plainStep(1'b1, 1'b0);
        plainStep(1'b0, 1'b1);
        plainStep(1'b0, 1'b0);
    endtask

    task automatic applyStep(input stepT s, input bit fromTable);
        instT w;
        addrT pc4;
        logic [BHT_BITS-1:0] idx;
        logic isJ;
        logic isB;
        logic pred;
        logic mis;
        logic issue;
        credit = s.credit;
        resValid = s.rv;
        resPc = s.rpc;
        resTaken = s.rt;
        resPredTaken = s.rpt;
        resTarget = s.rtgt;
        @(negedge clk);
        w = memWord(mPc);
        pc4 = mPc + 32'd4;
        isJ = (w[31:26] == OP_J) || (w[31:26] == OP_JAL);
        isB = w[31:26] inside {OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
        pred = isB && mCtr[mPc[BHT_BITS+1:2]][1];
        mis = s.rv && (s.rt != s.rpt);
        issue = (mCredits > 0) && !mis;
        if (fromTable && (issue != s.expIssue)) begin
            $display("stimulus row at %0t ns expects issue %0b but the model gives %0b",
                     $time, s.expIssue, issue);
            stopOnError();
        end
        checkAddr("imemAddr_o", imemAddr, mPc);
        checkBit("instValid_o", instValid, issue);
        checkBit("predTaken_o", predTaken, issue && pred);
        if (issue) begin
            checkAddr("instPc_o", instPc, mPc);
            checkInst("instWord_o", instWord, w);
        end
        if (mis)
            mPc = s.rt ? s.rtgt : s.rpc + 32'd4;
        else if (issue && isJ)
            mPc = {pc4[31:28], w[25:0], 2'b00};
        else if (issue && pred)
            mPc = pc4 + ({{16{w[15]}}, w[15:0]} << 2);
        else if (issue)
            mPc = pc4;
        if (issue)
            mCredits--;
        if (s.credit)
            mCredits++;
        if (s.rv) begin
            idx = s.rpc[BHT_BITS+1:2];
            if (s.rt && mCtr[idx] != 2'd3)
                mCtr[idx] = mCtr[idx] + 2'd1;
            else if (!s.rt && mCtr[idx] != 2'd0)
                mCtr[idx] = mCtr[idx] - 2'd1;
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        wait (tableReady);
        #((steps.size() + 20) * 40);
        $display("watchdog expired before the tests finished");
        stopOnError();
    end

    initial begin
        stepT r;
        logic [31:0] rnd;
        clk = 1'b0;
        rstN = 1'b0;
        credit = 1'b0;
        resValid = 1'b0;
        resPc = '0;
        resTaken = 1'b0;
        resPredTaken = 1'b0;
        resTarget = '0;
        void'($urandom(65880));
        loadImage();
        buildTable();
        tableReady = 1'b1;
        mPc = PC_RESET;
        mCredits = CREDITS;
        foreach (mCtr[i]) mCtr[i] = CTR_INIT;
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        foreach (steps[i]) begin
            applyStep(steps[i], 1'b1);
        end
        // random credit returns, model decides issue
        for (int i = 0; i < RAND_CYCLES; i++) begin
            rnd = $urandom;
            r = '0;
            r.credit = rnd[0];
            applyStep(r, 1'b0);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/fetchPkg.sv
verilog/resolveIf.sv
verilog/branchPredict.sv
verilog/jumpPredict.sv
verilog/pcCtrl.sv
verilog/fetchFront.sv
verification/fetchFront_properties.sv
verification/fetchFront_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch front end simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module fetchFront_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VfetchFront_tb 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
